// File: rename_input.txt
# R src1 src2 dest exp_src1 exp_src2 exp_dest exp_dest_old | C phys_reg | W idle_cycles
# S stall_value checked after the pipeline drains, all numbers decimal
# identity map after reset, new registers from 32 upward
R 1 2 3 1 2 32 3
R 4 5 6 4 5 33 6
R 7 8 9 7 8 34 9
# back-to-back dependent renames
R 3 6 10 32 33 35 10
R 10 10 11 35 35 36 11
R 11 3 3 36 32 37 32
R 3 0 12 37 0 38 12
# r0 destination allocates nothing, r0 source reads 0
R 1 3 0 1 37 0 0
R 0 0 13 0 0 39 13
R 0 12 0 0 38 0 0
R 13 0 14 39 0 40 14
W 2
S 0
# use up the remaining 23 free registers with no commits
R 14 15 15 40 15 41 15
R 15 16 16 41 16 42 16
R 16 17 17 42 17 43 17
R 17 18 18 43 18 44 18
R 18 19 19 44 19 45 19
R 19 20 20 45 20 46 20
R 20 21 21 46 21 47 21
R 21 22 22 47 22 48 22
R 22 23 23 48 23 49 23
R 23 24 24 49 24 50 24
R 24 25 25 50 25 51 25
R 25 26 26 51 26 52 26
R 26 27 27 52 27 53 27
R 27 28 28 53 28 54 28
R 28 29 29 54 29 55 29
R 29 30 30 55 30 56 30
R 30 31 31 56 31 57 31
R 31 1 1 57 1 58 1
R 1 2 2 58 2 59 2
R 2 3 3 59 37 60 37
R 3 4 4 60 4 61 4
R 4 5 5 61 5 62 5
R 5 6 6 62 33 63 33
# free list empty
S 1
# commit of physical 0 is ignored
C 0
S 1
# one commit lifts the stall and is handed out next
C 3
S 0
R 6 0 7 63 0 3 7
# committed registers come back in commit order
C 6
C 9
R 7 7 8 3 3 6 8
R 8 3 9 6 60 9 34
S 1

// File: register_renamer.f
+incdir+.
rename_pkg.sv
rename_map.sv
free_list.sv
register_renamer.sv
tb_register_renamer.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_register_renamer
RTL_TOP    = register_renamer
FILELIST   = register_renamer.f
OBJ_DIR    = obj_dir
PASS_MSG   = TESTS PASSED

SOURCES = $(wildcard *.sv *.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass message shows up in its output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_register_renamer.sv
`timescale 1ns/1ps

module tb_register_renamer import rename_pkg::*; ();

    localparam string INPUT_FILE      = "rename_input.txt";
    localparam int    CLK_PERIOD      = 8;
    localparam int    RESET_CYCLES    = 3;
    localparam int    CYCLES_PER_LINE = 20;
    localparam int    EXTRA_CYCLES    = 100;
    localparam int    DRAIN_CYCLES    = 8;     // well past the two-edge latency

    // DUT ports
    logic      clk;
    logic      reset;
    logic      rename_valid;
    arch_ops_t rename_ops;
    logic      commit_valid;
    phys_reg_t commit_reg;
    logic      out_valid;
    phys_ops_t out_ops;
    logic      stall;

    // results still to come out of the DUT, oldest first
    phys_ops_t expected_q [$];

    int   error_count = 0;
    int   check_count = 0;
    int   line_count  = 0;
    logic lines_known = 1'b0;   // watchdog starts once the file length is known

    register_renamer i_dut (
        .clk          (clk),
        .reset        (reset),
        .rename_valid (rename_valid),
        .rename_ops   (rename_ops),
        .stall        (stall),
        .out_valid    (out_valid),
        .out_ops      (out_ops),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic arch_ops_t make_request(input int src1, input int src2, input int dest);
        arch_ops_t ops;
        ops.src1 = arch_reg_t'(src1);
        ops.src2 = arch_reg_t'(src2);
        ops.dest = arch_reg_t'(dest);
        return ops;
    endfunction

    function automatic phys_ops_t make_result(input int src1, input int src2,
                                              input int dest, input int dest_old);
        phys_ops_t ops;
        ops.src1     = phys_reg_t'(src1);
        ops.src2     = phys_reg_t'(src2);
        ops.dest     = phys_reg_t'(dest);
        ops.dest_old = phys_reg_t'(dest_old);
        return ops;
    endfunction

    // file length sets the watchdog limit
    task automatic count_lines(output int lines);
        int    fd;
        string text;
        lines = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_rename(input arch_ops_t ops, input phys_ops_t expected);
        @(posedge clk);
        rename_valid <= 1'b1;
        rename_ops   <= ops;
        commit_valid <= 1'b0;
        expected_q.push_back(expected);
    endtask

    task automatic drive_commit(input phys_reg_t preg);
        @(posedge clk);
        rename_valid <= 1'b0;
        commit_valid <= 1'b1;
        commit_reg   <= preg;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            rename_valid <= 1'b0;
            commit_valid <= 1'b0;
        end
    endtask

    // idle until every queued result has come out, bounded
    task automatic wait_drained();
        int waited;
        waited = 0;
        drive_idle(1);
        while (expected_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic check_stall(input logic expected);
        wait_drained();
        @(negedge clk);                  // stall is settled mid-cycle
        check_count++;
        if (stall !== expected) begin
            $display("[FAIL] stall got 0x%h expected 0x%h at %0t", stall, expected, $time);
            error_count++;
        end
    endtask

    task automatic compare_result(input phys_ops_t expected, input phys_ops_t actual);
        check_count++;
        if (actual.src1 !== expected.src1) begin
            $display("[FAIL] out_ops.src1 got 0x%h expected 0x%h at %0t",
                     actual.src1, expected.src1, $time);
            error_count++;
        end
        if (actual.src2 !== expected.src2) begin
            $display("[FAIL] out_ops.src2 got 0x%h expected 0x%h at %0t",
                     actual.src2, expected.src2, $time);
            error_count++;
        end
        if (actual.dest !== expected.dest) begin
            $display("[FAIL] out_ops.dest got 0x%h expected 0x%h at %0t",
                     actual.dest, expected.dest, $time);
            error_count++;
        end
        if (actual.dest_old !== expected.dest_old) begin
            $display("[FAIL] out_ops.dest_old got 0x%h expected 0x%h at %0t",
                     actual.dest_old, expected.dest_old, $time);
            error_count++;
        end
    endtask

    // result checker, outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (expected_q.size() == 0) begin
                $display("out_valid was high with no rename waiting for a result at %0t", $time);
                error_count++;
            end else begin
                compare_result(expected_q.pop_front(), out_ops);
            end
        end
    end

    // the decoder side must hold off while stall is high
    always @(negedge clk) begin
        if (!reset && rename_valid && stall) begin
            $display("a rename was issued while stall was high at %0t", $time);
            error_count++;
        end
    end

    initial begin
        wait (lines_known);
        repeat (line_count * CYCLES_PER_LINE + EXTRA_CYCLES) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("checks: %0d  errors: %0d", check_count, error_count);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int    fd;
        int    code;
        int    fields [7];
        string op;
        string rest;
        logic  file_ok;

        reset        = 1'b1;
        rename_valid = 1'b0;
        rename_ops   = '0;
        commit_valid = 1'b0;
        commit_reg   = '0;
        file_ok      = 1'b1;

        count_lines(line_count);
        lines_known = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", INPUT_FILE);
            error_count++;
            file_ok = 1'b0;
        end

        while (file_ok && $fscanf(fd, " %s", op) == 1) begin
            if (op.getc(0) == "#") begin
                code = $fgets(rest, fd);             // skip the comment text
            end else if (op == "R") begin
                code = $fscanf(fd, " %d %d %d %d %d %d %d", fields[0], fields[1],
                               fields[2], fields[3], fields[4], fields[5], fields[6]);
                if (code != 7) begin
                    $display("a rename line in %s is missing values", INPUT_FILE);
                    error_count++;
                    file_ok = 1'b0;
                end else begin
                    drive_rename(make_request(fields[0], fields[1], fields[2]),
                                 make_result(fields[3], fields[4], fields[5], fields[6]));
                end
            end else if (op == "C" || op == "W" || op == "S") begin
                code = $fscanf(fd, " %d", fields[0]);
                if (code != 1) begin
                    $display("a line of type %s in %s has no value", op, INPUT_FILE);
                    error_count++;
                    file_ok = 1'b0;
                end else if (op == "C") begin
                    drive_commit(phys_reg_t'(fields[0]));
                end else if (op == "W") begin
                    drive_idle(fields[0]);
                end else begin
                    check_stall(fields[0] != 0);
                end
            end else begin
                $display("unknown operation %s in %s", op, INPUT_FILE);
                error_count++;
                file_ok = 1'b0;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        wait_drained();
        @(negedge clk);
        if (expected_q.size() != 0) begin
            $display("%0d renamed results never appeared on out_ops", expected_q.size());
            error_count += int'(expected_q.size());
        end

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: register_renamer.sv
`timescale 1ns/1ps

module register_renamer import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // decoder side
    input  logic      rename_valid,
    input  arch_ops_t rename_ops,
    output logic      stall,

    // renamed result without back-pressure
    output logic      out_valid,
    output phys_ops_t out_ops,

    // retire side
    input  logic      commit_valid,
    input  phys_reg_t commit_reg
);

    // stage 1 request register
    logic      req_valid;
    arch_ops_t req_ops;

    // stage 2 lookup and allocation
    logic      dest_is_r0;
    logic      need_alloc;
    phys_ops_t mapped_ops;
    phys_ops_t result_ops;
    phys_reg_t alloc_reg;
    free_cnt_t free_count;

    // commit side
    logic      release_en;

    // requests arriving while stall is high are dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= rename_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        req_ops <= rename_ops;
    end

    // r0 destination takes no register and leaves the map alone
    assign dest_is_r0 = (req_ops.dest == '0);
    assign need_alloc = req_valid && !dest_is_r0;

    // physical 0 is never handed back
    assign release_en = commit_valid && (commit_reg != '0);

    // no register to promise when the list is empty or the last one
    // is about to go to the request now in stage 1
    assign stall = (free_count == '0) ||
                   ((free_count == free_cnt_t'(1)) && need_alloc);

    rename_map i_map (
        .clk        (clk),
        .reset      (reset),
        .lookup_ops (req_ops),
        .write_en   (need_alloc),
        .write_reg  (alloc_reg),
        .mapped_ops (mapped_ops)
    );

    free_list i_free (
        .clk         (clk),
        .reset       (reset),
        .alloc       (need_alloc),
        .release_en  (release_en),
        .release_reg (commit_reg),
        .alloc_reg   (alloc_reg),
        .free_count  (free_count)
    );

    // assemble the renamed operands
    always_comb begin
        result_ops.src1 = mapped_ops.src1;   // r0 source reads map entry 0 which stays 0
        result_ops.src2 = mapped_ops.src2;
        if (dest_is_r0) begin
            result_ops.dest     = '0;
            result_ops.dest_old = '0;
        end else begin
            result_ops.dest     = alloc_reg;
            result_ops.dest_old = mapped_ops.dest_old;
        end
    end

    // output register two edges after the request was sampled
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_ops <= result_ops;
    end

endmodule

// File: free_list.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module free_list import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      alloc,        // take the head entry this cycle
    input  logic      release_en,   // push release_reg at the tail
    input  phys_reg_t release_reg,
    output phys_reg_t alloc_reg,    // current head
    output free_cnt_t free_count
);

    // circular queue of free physical registers
    // the pointers simply wrap since PHYS_REGS is a power of two
    phys_reg_t slots [`PHYS_REGS];

    phys_reg_t head;   // next register to hand out
    phys_reg_t tail;   // next empty slot
    free_cnt_t count;

    // head entry is offered every cycle and alloc only moves the pointer
    assign alloc_reg  = slots[head];
    assign free_count = count;

    // slot storage
    // on reset the upper half of the register file is queued in order
    // and the remaining slots hold nothing valid until a release fills them
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                slots[i] <= phys_reg_t'(`ARCH_REGS + i);
            end
        end else if (release_en) begin
            slots[tail] <= release_reg;
        end
    end

    // pointers
    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= phys_reg_t'(`ARCH_REGS);   // first free slot after the fill
        end else begin
            if (alloc) begin
                head <= head + 1'b1;
            end
            if (release_en) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // count of queued registers
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= free_cnt_t'(`ARCH_REGS);
        end else begin
            case ({alloc, release_en})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;     // both or neither leaves it as is
            endcase
        end
    end

    // a released register written at the tail of an empty queue is
    // visible at the head from the next cycle and can be allocated right away

    // alloc on an empty queue is kept out by the stall logic in the top

endmodule

// File: rename_map.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_map import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  arch_ops_t lookup_ops,  // request held in stage 1
    input  logic      write_en,    // new mapping for lookup_ops.dest
    input  phys_reg_t write_reg,
    output phys_ops_t mapped_ops
);

    // register alias table, one physical index per architectural register
    phys_reg_t map_table [`ARCH_REGS];

    // source and old-destination lookups
    // these see the table as it stands before this cycle's write,
    // the write lands on the same edge that registers the result
    phys_reg_t src1_phys;
    phys_reg_t src2_phys;
    phys_reg_t dest_old_phys;

    always_comb begin
        src1_phys     = map_table[lookup_ops.src1];
        src2_phys     = map_table[lookup_ops.src2];
        dest_old_phys = map_table[lookup_ops.dest];
    end

    always_comb begin
        mapped_ops.src1     = src1_phys;
        mapped_ops.src2     = src2_phys;
        mapped_ops.dest     = '0;              // top inserts the allocated register
        mapped_ops.dest_old = dest_old_phys;
    end

    // identity map after reset, r0 stays on physical 0 for good
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_table[i] <= phys_reg_t'(i);
            end
        end else if (write_en) begin
            // top never asserts write_en for an r0 destination
            map_table[lookup_ops.dest] <= write_reg;
        end
    end

    // a request right behind a dependent one is looked up one edge
    // after this write, so it already reads the new mapping

endmodule

// File: rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

    // index types
    typedef logic [`ARCH_ADDR_LEN-1:0] arch_reg_t;
    typedef logic [`PHYS_ADDR_LEN-1:0] phys_reg_t;

    // number of entries waiting in the free list
    typedef logic [`FREE_CNT_LEN-1:0] free_cnt_t;

    // one decoded instruction, architectural operands
    typedef struct packed {
        arch_reg_t src1;
        arch_reg_t src2;
        arch_reg_t dest;
    } arch_ops_t;

    // renamed operands
    // dest_old goes to the ROB and is freed at retire
    typedef struct packed {
        phys_reg_t src1;
        phys_reg_t src2;
        phys_reg_t dest;
        phys_reg_t dest_old;
    } phys_ops_t;

endpackage

// File: rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// index widths
`define ARCH_ADDR_LEN 5
`define PHYS_ADDR_LEN 6

// free count has to reach PHYS_REGS itself
`define FREE_CNT_LEN 7

`endif
